/* common/issue_defines.svh */
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// --------------------
// datapath widths
// --------------------

// integer operand and register width
`define ISSUE_XLEN 64
// virtual pc width, sign-extended into operand a
`define ISSUE_VLEN 39

// --------------------
// register file
// --------------------

`define ISSUE_REG_ADDR_W 5
`define ISSUE_NR_REGS 32
// scoreboard slot id
`define ISSUE_TRANS_ID_W 3
// commit ports writing the gpr file
`define ISSUE_NR_COMMIT_PORTS 2

`endif

/* common/issue_pkg.sv */
`include "issue_defines.svh"

package issue_pkg;

    // --------------------
    // plain vector types
    // --------------------

    typedef logic [`ISSUE_XLEN-1:0]       xlen_t;
    typedef logic [`ISSUE_VLEN-1:0]       vaddr_t;
    typedef logic [`ISSUE_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`ISSUE_TRANS_ID_W-1:0] trans_id_t;
    // operation code, only passed through to the units
    typedef logic [6:0]                   fu_op_t;

    // target or producing functional unit
    // NONE must stay zero, reset values rely on it
    typedef enum logic [3:0] {
        NONE      = 4'd0,
        ALU       = 4'd1,
        CTRL_FLOW = 4'd2,
        MULT      = 4'd3,
        LOAD      = 4'd4,
        STORE     = 4'd5,
        CSR       = 4'd6
    } fu_t;

    // per register: unit that will write it, or NONE
    typedef fu_t [`ISSUE_NR_REGS-1:0] clobber_t;

    // --------------------
    // packed structs
    // --------------------

    // decoded entry handed over by the scoreboard
    typedef struct packed {
        vaddr_t    pc;
        trans_id_t trans_id;
        fu_t       fu;
        fu_op_t    op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        xlen_t     result;        // immediate lives here
        logic      use_imm;
        logic      use_zimm;
        logic      use_pc;
        logic      ex_valid;      // entry already carries an exception
        logic      is_compressed;
    } issue_entry_t;

    // operands as seen by the functional units
    typedef struct packed {
        fu_t       fu;
        fu_op_t    op;
        xlen_t     operand_a;
        xlen_t     operand_b;
        xlen_t     imm;
        trans_id_t trans_id;
    } fu_data_t;

    // one commit write port into the gpr file
    typedef struct packed {
        reg_addr_t waddr;
        xlen_t     wdata;
        logic      we;
    } commit_port_t;

endpackage

/* dv/issue_tests.svh */
`ifndef ISSUE_TESTS_SVH
`define ISSUE_TESTS_SVH

// --------------------
// register file
// --------------------

task automatic regfile_readback();
    issue_entry_t e;
    xlen_t        d0;
    xlen_t        d1;
    d0 = rand_word();
    d1 = rand_word();
    commit_pair(5'd3, d0, 1'b1, 5'd7, d1, 1'b1);
    // same register on both ports
    commit_pair(5'd9, rand_word(), 1'b1, 5'd9, rand_word(), 1'b1);
    // x0 write is dropped, disabled port writes nothing
    commit_pair(5'd0, rand_word(), 1'b1, 5'd12, rand_word(), 1'b0);
    e = make_entry(ALU, 5'd3, 5'd7, 5'd1);
    issue_and_check(e, model_regs[3], model_regs[7]);
    e = make_entry(ALU, 5'd9, 5'd0, 5'd2);
    issue_and_check(e, model_regs[9], model_regs[0]);
    e = make_entry(ALU, 5'd0, 5'd12, 5'd2);
    issue_and_check(e, model_regs[0], model_regs[12]);
endtask

// --------------------
// forwarding
// --------------------

task automatic forward_and_stall();
    issue_entry_t e;
    xlen_t        fwd_a;
    xlen_t        fwd_b;
    fwd_a = rand_word();
    fwd_b = rand_word();
    @(posedge clk);
    clobber[3] <= ALU;
    rs1_vld    <= 1'b1;
    rs1_data   <= fwd_a;
    e = make_entry(ALU, 5'd3, 5'd7, 5'd10);
    issue_and_check(e, fwd_a, model_regs[7]);
    // rs2 from a load result
    @(posedge clk);
    clobber[3] <= NONE;
    clobber[7] <= LOAD;
    rs2_vld    <= 1'b1;
    rs2_data   <= fwd_b;
    e = make_entry(ALU, 5'd3, 5'd7, 5'd10);
    issue_and_check(e, model_regs[3], fwd_b);
    // producer not done yet
    @(posedge clk);
    clear_clobber();
    clobber[3] <= ALU;
    rs1_vld    <= 1'b0;
    rs2_vld    <= 1'b0;
    e = make_entry(ALU, 5'd3, 5'd7, 5'd10);
    drive_entry(e);
    expect_no_ack(3, "ack with rs1 not ready");
    // csr results cannot be forwarded
    @(posedge clk);
    clobber[3] <= CSR;
    rs1_vld    <= 1'b1;
    expect_no_ack(3, "ack with csr producer");
    @(posedge clk);
    valid   <= 1'b0;
    rs1_vld <= 1'b0;
    clear_clobber();
    @(negedge clk);
    check_strobes(5'b0, "strobe after withdrawn entry");
endtask

// --------------------
// write after write
// --------------------

task automatic waw_hazard();
    issue_entry_t e;
    xlen_t        d;
    d = rand_word();
    @(posedge clk);
    clobber[15] <= MULT;
    e = make_entry(ALU, 5'd3, 5'd7, 5'd15);
    drive_entry(e);
    expect_no_ack(3, "ack with rd clobbered");
    @(posedge clk);
    commit[1].waddr <= 5'd15;
    commit[1].wdata <= d;
    commit[1].we    <= 1'b1;
    @(negedge clk);
    check_value(issue_ack, 1'b1, "ack in rd commit cycle");
    @(posedge clk);
    commit      <= '0;
    valid       <= 1'b0;
    clobber[15] <= NONE;
    model_regs[15] = d;
    @(negedge clk);
    check_strobes(strobe_mask(ALU), "alu strobe after waw clears");
    check_value(fu_data.operand_a, model_regs[3], "operand a after waw");
endtask

// --------------------
// routing and back-pressure
// --------------------

task automatic unit_routing();
    issue_entry_t e;
    fu_t          units [0:5];
    units[0] = ALU;
    units[1] = CTRL_FLOW;
    units[2] = MULT;
    units[3] = LOAD;
    units[4] = STORE;
    units[5] = CSR;
    for (int i = 0; i < 6; i++) begin
        e = make_entry(units[i], 5'd3, 5'd9, 5'd20);
        issue_and_check(e, model_regs[3], model_regs[9]);
    end
    // flu busy, lsu still free
    @(posedge clk);
    flu_ready <= 1'b0;
    e = make_entry(LOAD, 5'd7, 5'd3, 5'd21);
    issue_and_check(e, model_regs[7], model_regs[3]);
    e = make_entry(ALU, 5'd7, 5'd3, 5'd21);
    drive_entry(e);
    expect_no_ack(2, "alu ack with flu busy");
    @(posedge clk);
    flu_ready <= 1'b1;
    complete_issue(e, model_regs[7], model_regs[3]);
    // lsu busy, flu still free
    @(posedge clk);
    lsu_ready <= 1'b0;
    e = make_entry(CSR, 5'd9, 5'd7, 5'd22);
    issue_and_check(e, model_regs[9], model_regs[7]);
    e = make_entry(STORE, 5'd9, 5'd7, 5'd22);
    drive_entry(e);
    expect_no_ack(2, "store ack with lsu busy");
    @(posedge clk);
    lsu_ready <= 1'b1;
    complete_issue(e, model_regs[9], model_regs[7]);
    // no unit, and an exception held on a stalled operand
    e = make_entry(NONE, 5'd3, 5'd7, 5'd23);
    issue_and_check(e, model_regs[3], model_regs[7]);
    @(posedge clk);
    clobber[3] <= CSR;
    e = make_entry(ALU, 5'd3, 5'd7, 5'd23);
    e.ex_valid = 1'b1;
    issue_and_check(e, model_regs[3], model_regs[7]);
    @(posedge clk);
    clear_clobber();
endtask

// --------------------
// operand selection
// --------------------

task automatic operand_selection();
    issue_entry_t e;
    xlen_t        exp_a;
    e = make_entry(ALU, 5'd3, 5'd7, 5'd24);
    e.pc[`ISSUE_VLEN-1] = 1'b1;
    e.use_pc = 1'b1;
    // pc top bit set, so every bit above the pc is one
    exp_a = '1;
    exp_a[`ISSUE_VLEN-1:0] = e.pc;
    issue_and_check(e, exp_a, model_regs[7]);
    // zimm beats pc, clobbered rs1 does not stall it
    @(posedge clk);
    clobber[17] <= CSR;
    e = make_entry(CSR, 5'd17, 5'd7, 5'd24);
    e.use_zimm = 1'b1;
    e.use_pc = 1'b1;
    exp_a = '0;
    exp_a[4:0] = 5'd17;
    issue_and_check(e, exp_a, model_regs[7]);
    @(posedge clk);
    clear_clobber();
    e = make_entry(ALU, 5'd3, 5'd7, 5'd24);
    e.use_imm = 1'b1;
    issue_and_check(e, model_regs[3], e.result);
    // store data and branch compare keep rs2
    e = make_entry(STORE, 5'd3, 5'd7, 5'd24);
    e.use_imm = 1'b1;
    issue_and_check(e, model_regs[3], model_regs[7]);
    e = make_entry(CTRL_FLOW, 5'd3, 5'd7, 5'd24);
    e.use_imm = 1'b1;
    issue_and_check(e, model_regs[3], model_regs[7]);
endtask

// --------------------
// flush and mult
// --------------------

task automatic flush_and_mult_block();
    issue_entry_t e;
    issue_entry_t e_mul;
    e = make_entry(ALU, 5'd3, 5'd7, 5'd25);
    @(posedge clk);
    instr <= e;
    valid <= 1'b1;
    flush <= 1'b1;
    @(negedge clk);
    check_value(issue_ack, 1'b1, "ack during flush");
    @(posedge clk);
    valid <= 1'b0;
    flush <= 1'b0;
    @(negedge clk);
    check_strobes(5'b0, "strobe after flush");
    // back to back mults, then an alu behind them
    e = make_entry(MULT, 5'd3, 5'd7, 5'd26);
    drive_entry(e);
    wait_for_ack("first mult");
    e_mul = make_entry(MULT, 5'd9, 5'd3, 5'd27);
    @(posedge clk);
    instr <= e_mul;
    @(negedge clk);
    check_value(mult_valid, 1'b1, "first mult strobe");
    check_value(issue_ack, 1'b1, "mult ack after mult");
    e = make_entry(ALU, 5'd3, 5'd7, 5'd28);
    @(posedge clk);
    instr <= e;
    @(negedge clk);
    check_value(mult_valid, 1'b1, "second mult strobe");
    check_value(fu_data.trans_id, e_mul.trans_id, "second mult trans_id");
    check_value(issue_ack, 1'b0, "alu ack after mult");
    complete_issue(e, model_regs[3], model_regs[7]);
endtask

`endif

/* dv/issue_tb.sv */
`timescale 1ns/10ps
`include "issue_defines.svh"

module issue_tb import issue_pkg::*; ();

    localparam int ACK_TIMEOUT = 20;

    // dut side signals
    logic                 clk;
    logic                 rst_n;
    logic                 flush;
    issue_entry_t         instr;
    logic                 valid;
    logic                 issue_ack;
    reg_addr_t            rs1_addr;
    reg_addr_t            rs2_addr;
    xlen_t                rs1_data;
    xlen_t                rs2_data;
    logic                 rs1_vld;
    logic                 rs2_vld;
    clobber_t             clobber;
    commit_port_t [1:0]   commit;
    logic                 flu_ready;
    logic                 lsu_ready;
    fu_data_t             fu_data;
    vaddr_t               pc;
    logic                 is_compressed;
    logic                 alu_valid;
    logic                 branch_valid;
    logic                 mult_valid;
    logic                 lsu_valid;
    logic                 csr_valid;

    // expected register contents, x0 never written
    xlen_t  model_regs [0:`ISSUE_NR_REGS-1];
    integer seed;

    always #2 clk = ~clk;

    issue_stage_top #(
        .NR_COMMIT_PORTS(2)
    ) UUT (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .flush_i         (flush),
        .issue_instr_i   (instr),
        .issue_valid_i   (valid),
        .issue_ack_o     (issue_ack),
        .rs1_o           (rs1_addr),
        .rs2_o           (rs2_addr),
        .rs1_i           (rs1_data),
        .rs2_i           (rs2_data),
        .rs1_valid_i     (rs1_vld),
        .rs2_valid_i     (rs2_vld),
        .clobber_i       (clobber),
        .commit_i        (commit),
        .flu_ready_i     (flu_ready),
        .lsu_ready_i     (lsu_ready),
        .fu_data_o       (fu_data),
        .pc_o            (pc),
        .is_compressed_o (is_compressed),
        .alu_valid_o     (alu_valid),
        .branch_valid_o  (branch_valid),
        .mult_valid_o    (mult_valid),
        .lsu_valid_o     (lsu_valid),
        .csr_valid_o     (csr_valid)
    );

    // --------------------
    // check and helpers
    // --------------------

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s (got %h, expected %h)", $time, msg, actual, expected);
            $display("Checks failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    function automatic xlen_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    // one-hot {alu, branch, mult, lsu, csr} for a unit
    function automatic logic [4:0] strobe_mask(input fu_t fu);
        case (fu)
            ALU:         return 5'b10000;
            CTRL_FLOW:   return 5'b01000;
            MULT:        return 5'b00100;
            LOAD, STORE: return 5'b00010;
            CSR:         return 5'b00001;
            default:     return 5'b00000;
        endcase
    endfunction

    // plain entry, no immediates, no exception
    function automatic issue_entry_t make_entry(input fu_t fu, input reg_addr_t rs1,
                                                input reg_addr_t rs2, input reg_addr_t rd);
        issue_entry_t e;
        xlen_t        rnd;
        e = '0;
        rnd = rand_word();
        e.pc = rnd[`ISSUE_VLEN-1:0];
        e.trans_id = rnd[63:61];
        e.op = rnd[59:53];
        e.is_compressed = rnd[60];
        e.fu = fu;
        e.rs1 = rs1;
        e.rs2 = rs2;
        e.rd = rd;
        e.result = rand_word();
        return e;
    endfunction

    // both ports write at one edge, port 1 lands last in the model
    task automatic commit_pair(input reg_addr_t a0, input xlen_t d0, input logic we0,
                               input reg_addr_t a1, input xlen_t d1, input logic we1);
        @(posedge clk);
        commit[0].waddr <= a0;
        commit[0].wdata <= d0;
        commit[0].we    <= we0;
        commit[1].waddr <= a1;
        commit[1].wdata <= d1;
        commit[1].we    <= we1;
        @(posedge clk);
        commit <= '0;
        if (we0 && (a0 != 0)) model_regs[a0] = d0;
        if (we1 && (a1 != 0)) model_regs[a1] = d1;
    endtask

    task automatic clear_clobber();
        for (int i = 0; i < `ISSUE_NR_REGS; i++) begin
            clobber[i] <= NONE;
        end
    endtask

    task automatic drive_entry(input issue_entry_t e);
        @(posedge clk);
        instr <= e;
        valid <= 1'b1;
    endtask

    // sampled mid-cycle where the combinational ack has settled
    task automatic wait_for_ack(input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!issue_ack && (waited < ACK_TIMEOUT)) begin
            waited++;
            @(negedge clk);
        end
        if (!issue_ack) begin
            $display("timeout: issue acknowledge never arrived for %s", what);
            $display("Checks failed");
            $fatal(1, "stopping on timeout");
        end
    endtask

    task automatic check_strobes(input logic [4:0] expected, input string msg);
        check_value({alu_valid, branch_valid, mult_valid, lsu_valid, csr_valid}, expected, msg);
    endtask

    // entry is held, ack stays low and nothing is strobed
    task automatic expect_no_ack(input int cycles, input string msg);
        repeat (cycles) begin
            @(negedge clk);
            check_value(issue_ack, 1'b0, msg);
            check_strobes(5'b0, {msg, " strobe"});
        end
    endtask

    // entry already driven, wait for ack and check the id/ex outputs
    task automatic complete_issue(input issue_entry_t e, input xlen_t exp_a, input xlen_t exp_b);
        wait_for_ack("issued entry");
        // scoreboard lookup indices come straight from the entry
        check_value(rs1_addr, e.rs1, "rs1 lookup index");
        check_value(rs2_addr, e.rs2, "rs2 lookup index");
        @(posedge clk);
        valid <= 1'b0;
        @(negedge clk);
        check_strobes(e.ex_valid ? 5'b0 : strobe_mask(e.fu), "unit strobe");
        check_value(fu_data.operand_a, exp_a, "operand a");
        check_value(fu_data.operand_b, exp_b, "operand b");
        check_value(fu_data.imm, e.result, "imm");
        check_value(fu_data.fu, e.fu, "fu");
        check_value(fu_data.op, e.op, "op");
        check_value(fu_data.trans_id, e.trans_id, "trans_id");
        check_value(pc, e.pc, "pc");
        check_value(is_compressed, e.is_compressed, "is_compressed");
    endtask

    task automatic issue_and_check(input issue_entry_t e, input xlen_t exp_a, input xlen_t exp_b);
        drive_entry(e);
        complete_issue(e, exp_a, exp_b);
    endtask

    `include "issue_tests.svh"

    // --------------------
    // run sequence
    // --------------------

    initial begin
        seed = 32'h2d1f_704a;
        clk = 1'b0;
        rst_n = 1'b0;
        flush = 1'b0;
        instr = '0;
        valid = 1'b0;
        rs1_data = '0;
        rs2_data = '0;
        rs1_vld = 1'b0;
        rs2_vld = 1'b0;
        commit = '0;
        flu_ready = 1'b1;
        lsu_ready = 1'b1;
        for (int i = 0; i < `ISSUE_NR_REGS; i++) begin
            clobber[i] = NONE;
            model_regs[i] = '0;
        end

        // two cycles of reset, state checked inside it
        @(posedge clk);
        @(negedge clk);
        check_strobes(5'b0, "strobes in reset");
        check_value(fu_data.fu, NONE, "fu in reset");
        check_value(pc, '0, "pc in reset");
        @(posedge clk);
        rst_n <= 1'b1;

        regfile_readback();
        forward_and_stall();
        waw_hazard();
        unit_routing();
        operand_selection();
        flush_and_mult_block();

        $display("All checks passed");
        $finish;
    end

endmodule

/* list.f */
+incdir+common
+incdir+dv
common/issue_pkg.sv
operand_read/operand_hazard.sv
operand_read/operand_stage.sv
source/gpr_file.sv
source/issue_control.sv
source/issue_stage_top.sv
dv/issue_tb.sv

/* operand_read/operand_hazard.sv */
`timescale 1ns/10ps
`include "issue_defines.svh"

module operand_hazard import issue_pkg::*; (
    input  issue_entry_t issue_instr_i,
    input  clobber_t     clobber_i,
    // scoreboard result availability for rs1/rs2
    input  logic         rs1_valid_i,
    input  logic         rs2_valid_i,
    output logic         fwd_rs1_o,
    output logic         fwd_rs2_o,
    output logic         operand_stall_o
);

    // producers of the two sources
    fu_t rs1_producer;
    fu_t rs2_producer;

    assign rs1_producer = clobber_i[issue_instr_i.rs1];
    assign rs2_producer = clobber_i[issue_instr_i.rs2];

    // --------------------
    // source checks
    // --------------------

    // a clobbered source is either forwarded from the scoreboard
    // or holds the entry back
    // csr results never travel on the forward path
    always_comb begin
        fwd_rs1_o       = 1'b0;
        fwd_rs2_o       = 1'b0;
        operand_stall_o = 1'b0;

        // zimm encodes an immediate in rs1, nothing to wait for
        if (!issue_instr_i.use_zimm && (rs1_producer != NONE)) begin
            if (rs1_valid_i && (rs1_producer != CSR)) begin
                fwd_rs1_o = 1'b1;
            end else begin
                operand_stall_o = 1'b1;
            end
        end

        if (rs2_producer != NONE) begin
            if (rs2_valid_i && (rs2_producer != CSR)) begin
                fwd_rs2_o = 1'b1;
            end else begin
                operand_stall_o = 1'b1;
            end
        end
    end

endmodule

/* operand_read/operand_stage.sv */
`timescale 1ns/10ps
`include "issue_defines.svh"

module operand_stage import issue_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  issue_entry_t issue_instr_i,
    // register file data
    input  xlen_t        rdata_a_i,
    input  xlen_t        rdata_b_i,
    // forwarded scoreboard data
    input  logic         fwd_rs1_i,
    input  logic         fwd_rs2_i,
    input  xlen_t        rs1_i,
    input  xlen_t        rs2_i,
    // id/ex register
    output fu_data_t     fu_data_o,
    output vaddr_t       pc_o,
    output logic         is_compressed_o
);

    xlen_t operand_a_d;
    xlen_t operand_b_d;

    // --------------------
    // operand select
    // --------------------

    // later assignments override earlier ones, giving
    // regfile < forward < pc < zimm for operand a
    always_comb begin
        operand_a_d = fwd_rs1_i ? rs1_i : rdata_a_i;
        operand_b_d = fwd_rs2_i ? rs2_i : rdata_b_i;

        // auipc and jal style, pc sign-extended to xlen
        if (issue_instr_i.use_pc) begin
            operand_a_d = {{(`ISSUE_XLEN-`ISSUE_VLEN){issue_instr_i.pc[`ISSUE_VLEN-1]}},
                           issue_instr_i.pc};
        end

        // csr immediate forms carry uimm in the rs1 field
        if (issue_instr_i.use_zimm) begin
            operand_a_d = {{(`ISSUE_XLEN-`ISSUE_REG_ADDR_W){1'b0}}, issue_instr_i.rs1};
        end

        // stores need rs2 as data and branches compare rs2,
        // their immediate goes through imm instead
        if (issue_instr_i.use_imm && (issue_instr_i.fu != STORE)
                && (issue_instr_i.fu != CTRL_FLOW)) begin
            operand_b_d = issue_instr_i.result;
        end
    end

    // --------------------
    // id/ex register
    // --------------------

    // loads every cycle, the unit strobes qualify it
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_data_o.fu        <= NONE;
            fu_data_o.op        <= '0;
            fu_data_o.operand_a <= '0;
            fu_data_o.operand_b <= '0;
            fu_data_o.imm       <= '0;
            fu_data_o.trans_id  <= '0;
            pc_o                <= '0;
            is_compressed_o     <= 1'b0;
        end else begin
            fu_data_o.fu        <= issue_instr_i.fu;
            fu_data_o.op        <= issue_instr_i.op;
            fu_data_o.operand_a <= operand_a_d;
            fu_data_o.operand_b <= operand_b_d;
            fu_data_o.imm       <= issue_instr_i.result;
            fu_data_o.trans_id  <= issue_instr_i.trans_id;
            pc_o                <= issue_instr_i.pc;
            is_compressed_o     <= issue_instr_i.is_compressed;
        end
    end

endmodule

/* source/gpr_file.sv */
`timescale 1ns/10ps
`include "issue_defines.svh"

module gpr_file import issue_pkg::*; #(
    parameter int unsigned NR_COMMIT_PORTS = `ISSUE_NR_COMMIT_PORTS
) (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    // two combinational read ports
    input  reg_addr_t                          raddr_a_i,
    input  reg_addr_t                          raddr_b_i,
    output xlen_t                              rdata_a_o,
    output xlen_t                              rdata_b_o,
    // commit write ports
    input  commit_port_t [NR_COMMIT_PORTS-1:0] commit_i
);

    // x1..x31 only, x0 has no storage
    xlen_t regs_q [1:`ISSUE_NR_REGS-1];

    // --------------------
    // write ports
    // --------------------

    // ports are scanned in ascending order so the
    // highest-numbered port writing a register wins
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int unsigned r = 1; r < `ISSUE_NR_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
                // writes to x0 are dropped
                if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
                    regs_q[commit_i[p].waddr] <= commit_i[p].wdata;
                end
            end
        end
    end

    // --------------------
    // read ports
    // --------------------

    // no internal bypass, a write shows up after its edge
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* source/issue_control.sv */
`timescale 1ns/10ps
`include "issue_defines.svh"

module issue_control import issue_pkg::*; #(
    parameter int unsigned NR_COMMIT_PORTS = `ISSUE_NR_COMMIT_PORTS
) (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               flush_i,
    input  issue_entry_t                       issue_instr_i,
    input  logic                               issue_valid_i,
    input  logic                               operand_stall_i,
    input  clobber_t                           clobber_i,
    input  commit_port_t [NR_COMMIT_PORTS-1:0] commit_i,
    input  logic                               flu_ready_i,
    input  logic                               lsu_ready_i,
    output logic                               issue_ack_o,
    // one-cycle strobes towards the units
    output logic                               alu_valid_o,
    output logic                               branch_valid_o,
    output logic                               mult_valid_o,
    output logic                               lsu_valid_o,
    output logic                               csr_valid_o
);

    logic fu_busy;
    logic waw_clear;
    logic alu_valid_q;
    logic branch_valid_q;
    logic mult_valid_q;
    logic lsu_valid_q;
    logic csr_valid_q;

    // --------------------
    // unit busy
    // --------------------

    // fixed latency units share flu_ready, memory ops use the lsu
    always_comb begin
        unique case (issue_instr_i.fu)
            ALU, CTRL_FLOW, MULT, CSR: fu_busy = ~flu_ready_i;
            LOAD, STORE:               fu_busy = ~lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // --------------------
    // write after write
    // --------------------

    // rd is free, or its pending producer commits this very cycle
    always_comb begin
        waw_clear = (clobber_i[issue_instr_i.rd] == NONE);
        for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].we && (commit_i[p].waddr == issue_instr_i.rd)) begin
                waw_clear = 1'b1;
            end
        end
    end

    // --------------------
    // issue acknowledge
    // --------------------

    always_comb begin
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (!operand_stall_i && !fu_busy && waw_clear) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less entries drain without operands
            if (issue_instr_i.ex_valid || (issue_instr_i.fu == NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // the multiplier result bus is busy next cycle, only another mult fits
        if (mult_valid_q && (issue_instr_i.fu != MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

    // --------------------
    // unit strobes
    // --------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            alu_valid_q    <= 1'b0;
            branch_valid_q <= 1'b0;
            mult_valid_q   <= 1'b0;
            lsu_valid_q    <= 1'b0;
            csr_valid_q    <= 1'b0;
        end else begin
            // strobes last exactly one cycle
            // a flush kills whatever would start now
            alu_valid_q    <= 1'b0;
            branch_valid_q <= 1'b0;
            mult_valid_q   <= 1'b0;
            lsu_valid_q    <= 1'b0;
            csr_valid_q    <= 1'b0;
            if (issue_ack_o && !issue_instr_i.ex_valid && !flush_i) begin
                unique case (issue_instr_i.fu)
                    ALU:         alu_valid_q    <= 1'b1;
                    CTRL_FLOW:   branch_valid_q <= 1'b1;
                    MULT:        mult_valid_q   <= 1'b1;
                    LOAD, STORE: lsu_valid_q    <= 1'b1;
                    CSR:         csr_valid_q    <= 1'b1;
                    default:     ;
                endcase
            end
        end
    end

    assign alu_valid_o    = alu_valid_q;
    assign branch_valid_o = branch_valid_q;
    assign mult_valid_o   = mult_valid_q;
    assign lsu_valid_o    = lsu_valid_q;
    assign csr_valid_o    = csr_valid_q;

endmodule

/* source/issue_stage_top.sv */
`timescale 1ns/10ps
`include "issue_defines.svh"

module issue_stage_top import issue_pkg::*; #(
    parameter int unsigned NR_COMMIT_PORTS = `ISSUE_NR_COMMIT_PORTS
) (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               flush_i,
    // scoreboard issue side
    input  issue_entry_t                       issue_instr_i,
    input  logic                               issue_valid_i,
    output logic                               issue_ack_o,
    // scoreboard operand lookup
    output reg_addr_t                          rs1_o,
    output reg_addr_t                          rs2_o,
    input  xlen_t                              rs1_i,
    input  xlen_t                              rs2_i,
    input  logic                               rs1_valid_i,
    input  logic                               rs2_valid_i,
    input  clobber_t                           clobber_i,
    // commit stage writes
    input  commit_port_t [NR_COMMIT_PORTS-1:0] commit_i,
    // functional units
    input  logic                               flu_ready_i,
    input  logic                               lsu_ready_i,
    output fu_data_t                           fu_data_o,
    output vaddr_t                             pc_o,
    output logic                               is_compressed_o,
    output logic                               alu_valid_o,
    output logic                               branch_valid_o,
    output logic                               mult_valid_o,
    output logic                               lsu_valid_o,
    output logic                               csr_valid_o
);

    // hazard results shared by control and operand path
    logic  fwd_rs1;
    logic  fwd_rs2;
    logic  operand_stall;
    // gpr read data
    xlen_t rdata_a;
    xlen_t rdata_b;

    // scoreboard lookup uses the entry's sources directly
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;

    gpr_file #(
        .NR_COMMIT_PORTS(NR_COMMIT_PORTS)
    ) u_gpr_file (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .raddr_a_i (issue_instr_i.rs1),
        .raddr_b_i (issue_instr_i.rs2),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .commit_i  (commit_i)
    );

    operand_hazard u_operand_hazard (
        .issue_instr_i   (issue_instr_i),
        .clobber_i       (clobber_i),
        .rs1_valid_i     (rs1_valid_i),
        .rs2_valid_i     (rs2_valid_i),
        .fwd_rs1_o       (fwd_rs1),
        .fwd_rs2_o       (fwd_rs2),
        .operand_stall_o (operand_stall)
    );

    issue_control #(
        .NR_COMMIT_PORTS(NR_COMMIT_PORTS)
    ) u_issue_control (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .issue_instr_i   (issue_instr_i),
        .issue_valid_i   (issue_valid_i),
        .operand_stall_i (operand_stall),
        .clobber_i       (clobber_i),
        .commit_i        (commit_i),
        .flu_ready_i     (flu_ready_i),
        .lsu_ready_i     (lsu_ready_i),
        .issue_ack_o     (issue_ack_o),
        .alu_valid_o     (alu_valid_o),
        .branch_valid_o  (branch_valid_o),
        .mult_valid_o    (mult_valid_o),
        .lsu_valid_o     (lsu_valid_o),
        .csr_valid_o     (csr_valid_o)
    );

    operand_stage u_operand_stage (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .issue_instr_i   (issue_instr_i),
        .rdata_a_i       (rdata_a),
        .rdata_b_i       (rdata_b),
        .fwd_rs1_i       (fwd_rs1),
        .fwd_rs2_i       (fwd_rs2),
        .rs1_i           (rs1_i),
        .rs2_i           (rs2_i),
        .fu_data_o       (fu_data_o),
        .pc_o            (pc_o),
        .is_compressed_o (is_compressed_o)
    );

endmodule
